// File: Bender.yml
package:
  name: post_norm

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fpu_norm_pkg.sv
      - hdl/norm_ctrl.sv
      - hdl/norm_exp_counter.sv
      - hdl/norm_shifter.sv
      - hdl/norm_round.sv
      - hdl/post_norm.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/tb_post_norm.sv

// File: hdl/fpu_norm_defs.svh
// field widths and fixed positions for the single precision
// post normalisation unit
// the values follow the IEEE single format and are not meant to be
// changed; the fraction layout assumes the adder result has one carry
// bit above the hidden bit
`ifndef FPU_NORM_DEFS_SVH
`define FPU_NORM_DEFS_SVH

// --------------------
// widths

// adder result, carry and hidden bit included
`define FN_FRACT_W 48
// stored mantissa without the hidden bit
`define FN_MANT_W 23
`define FN_EXP_W 8

// --------------------
// positions and special values

// hidden bit of the working fraction, bit 47 above it is the carry
`define FN_HIDDEN 46
// all ones exponent, infinity
`define FN_EXP_INF 8'hff
// exponent of the largest finite number
`define FN_EXP_MAXN 8'hfe

`endif

// File: hdl/fpu_norm_pkg.sv
// shared types of the post normalisation unit
// widths come from the defs header, so any change there moves the
// types here along with it
// the rounding mode encoding matches the usual fpu rmode port

`include "fpu_norm_defs.svh"

package fpu_norm_pkg;

	// --------------------
	// data types

	// working fraction as delivered by the adder
	typedef logic [`FN_FRACT_W-1:0] fract_t;
	// mantissa field of the packed result
	typedef logic [`FN_MANT_W-1:0] mant_t;
	typedef logic [`FN_EXP_W-1:0] exp_t;
	// exponent and mantissa, no sign bit
	typedef logic [`FN_EXP_W+`FN_MANT_W-1:0] result_t;

	// --------------------
	// control types

	typedef enum logic [1:0] {
		rm_nearest = 2'd0,
		rm_zero    = 2'd1,
		rm_up      = 2'd2,
		rm_down    = 2'd3
	} rmode_e;

	// sequencer states, one item in flight at a time
	typedef enum logic [2:0] {
		st_idle,
		st_load,
		st_shift,
		st_round,
		st_hold
	} norm_state_e;

endpackage

// File: hdl/norm_ctrl.sv
// sequencer of the post normalisation unit
// four phase req/ack: ack rises after the round cycle and stays up
// until req is seen low, then drops one cycle later
// inputs must stay stable from req to ack, nothing is captured here
// latency depends on the number of leading zeros

`include "fpu_norm_defs.svh"

module norm_ctrl
	import fpu_norm_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic req,
	input  logic hidden_set,
	input  logic carry_set,
	input  logic fract_zero,
	input  logic at_floor,
	output logic load,
	output logic shift_left,
	output logic shift_right,
	output logic do_round,
	output logic ack
);

	norm_state_e state_q;
	norm_state_e state_d;
	logic in_shift;

	// --------------------
	// state register

	always_ff @(posedge clk) begin
		if (reset)
			state_q <= st_idle;
		else
			state_q <= state_d;
	end

	// --------------------
	// control decode

	assign in_shift = (state_q == st_shift);
	assign load = (state_q == st_load);
	// adder carry, one step to the right is always enough
	assign shift_right = in_shift & carry_set;
	// walk left until the hidden bit shows up or the exponent bottoms out
	assign shift_left = in_shift & ~carry_set & ~fract_zero & ~hidden_set & ~at_floor;
	assign do_round = (state_q == st_round);
	assign ack = (state_q == st_hold);

	always_comb begin
		state_d = state_q;
		case (state_q)
			st_idle: begin
				if (req)
					state_d = st_load;
			end
			// shifter and counter take the operands in this cycle
			st_load: state_d = st_shift;
			st_shift: begin
				// a zero fraction or a right shift needs no further steps
				if (!shift_left)
					state_d = st_round;
			end
			st_round: state_d = st_hold;
			st_hold: begin
				// result stays held while req is kept high
				if (!req)
					state_d = st_idle;
			end
			default: state_d = st_idle;
		endcase
	end

	// --------------------
	// checks

	// both directions at once would corrupt the fraction and exponent
	assert property (@(posedge clk) disable iff (reset)
		!(shift_left && shift_right))
		else $error("left and right shift requested together");

	// the result register must have been written before ack goes up
	assert property (@(posedge clk) disable iff (reset)
		$rose(ack) |-> $past(do_round))
		else $error("ack raised without a round cycle before it");

endmodule

// File: hdl/norm_exp_counter.sv
// exponent counter that tracks the normalisation shifts
// counts down on a left shift and up on a right shift
// the floor is exponent 1, below it the result becomes a denormal
// the up count holds at the all ones exponent and never wraps

`include "fpu_norm_defs.svh"

module norm_exp_counter
	import fpu_norm_pkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic load,
	input  exp_t exp_in,
	input  logic shift_left,
	input  logic shift_right,
	output exp_t exp_cur,
	output logic at_floor
);

	exp_t exp_q;
	logic at_top;

	// the up count stops here, the rounder turns it into an overflow
	assign at_top = (exp_q == `FN_EXP_INF);

	always_ff @(posedge clk) begin
		if (reset)
			exp_q <= '0;
		else if (load)
			exp_q <= exp_in;
		else if (shift_left)
			exp_q <= exp_q - exp_t'(1);
		else if (shift_right && !at_top)
			exp_q <= exp_q + exp_t'(1);
	end

	assign exp_cur = exp_q;
	// one or less, no further left shift allowed
	assign at_floor = (exp_q <= exp_t'(1));

	// the sequencer has to stop shifting once the floor is reached
	assert property (@(posedge clk) disable iff (reset)
		shift_left |-> !at_floor)
		else $error("left shift issued with the exponent at its floor");

endmodule

// File: hdl/norm_round.sv
// rounding and result packing for the normalised fraction
// mantissa is fraction bits 45:23, round bit 22, sticky from 21:0
// plus the bit lost by a right shift
// all four IEEE rounding modes; overflow goes to infinity or to the
// largest finite number depending on mode and sign
// a clear hidden bit gives a denormal with exponent field 0
// result and flags are registered on do_round and held afterwards

`include "fpu_norm_defs.svh"

module norm_round
	import fpu_norm_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    do_round,
	input  fract_t  fract_cur,
	input  logic    sticky_extra,
	input  exp_t    exp_cur,
	input  logic    sign,
	input  rmode_e  rmode,
	output result_t out,
	output logic    overflow,
	output logic    underflow,
	output logic    ine
);

	mant_t mant;
	logic hidden;
	logic lsb;
	logic rnd_bit;
	logic stk_bit;
	logic round_up;
	// hidden bit and mantissa after the increment, one bit of carry room
	logic [`FN_MANT_W+1:0] sig_rnd;
	logic [`FN_EXP_W:0] exp_rnd;
	logic norm_out;
	logic ovf;
	logic ovf_inf;
	logic inexact;
	exp_t exp_fld;
	mant_t mant_fld;

	// --------------------
	// guard bits

	assign hidden = fract_cur[`FN_HIDDEN];
	assign mant = fract_cur[`FN_HIDDEN-1 -: `FN_MANT_W];
	assign lsb = mant[0];
	assign rnd_bit = fract_cur[`FN_HIDDEN-`FN_MANT_W-1];
	assign stk_bit = (|fract_cur[`FN_HIDDEN-`FN_MANT_W-2:0]) | sticky_extra;

	// --------------------
	// rounding decision

	always_comb begin
		case (rmode)
			// ties go to the even mantissa
			rm_nearest: round_up = rnd_bit & (stk_bit | lsb);
			rm_up:      round_up = ~sign & (rnd_bit | stk_bit);
			rm_down:    round_up = sign & (rnd_bit | stk_bit);
			default:    round_up = 1'b0;
		endcase
	end

	// increment includes the hidden bit, so a denormal that rounds up
	// into the hidden position becomes the smallest normal number
	assign sig_rnd = {1'b0, hidden, mant} + (`FN_MANT_W+2)'(round_up);
	assign norm_out = sig_rnd[`FN_MANT_W+1] | sig_rnd[`FN_MANT_W];
	// carry out of the mantissa bumps the exponent, mantissa is then zero
	assign exp_rnd = {1'b0, exp_cur} + (`FN_EXP_W+1)'(sig_rnd[`FN_MANT_W+1]);

	// --------------------
	// overflow and packing

	assign ovf = (exp_rnd >= (`FN_EXP_W+1)'(`FN_EXP_INF));
	// infinity unless the mode rounds toward zero for this sign
	assign ovf_inf = (rmode == rm_nearest) |
		((rmode == rm_up) & ~sign) |
		((rmode == rm_down) & sign);

	always_comb begin
		if (ovf) begin
			exp_fld = ovf_inf ? `FN_EXP_INF : `FN_EXP_MAXN;
			mant_fld = ovf_inf ? '0 : '1;
		end else begin
			// denormal or zero when no hidden bit survived
			exp_fld = norm_out ? exp_rnd[`FN_EXP_W-1:0] : '0;
			mant_fld = sig_rnd[`FN_MANT_W-1:0];
		end
	end

	assign inexact = rnd_bit | stk_bit | ovf;

	// --------------------
	// result registers

	always_ff @(posedge clk) begin
		if (do_round)
			out <= {exp_fld, mant_fld};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			overflow <= 1'b0;
			underflow <= 1'b0;
			ine <= 1'b0;
		end else if (do_round) begin
			overflow <= ovf;
			// tiny and inexact
			underflow <= (exp_fld == '0) & inexact;
			ine <= inexact;
		end
	end

endmodule

// File: hdl/norm_shifter.sv
// working fraction register of the post normalisation unit
// one bit per shift pulse, left or right
// a bit shifted out on the right is kept in a sticky bit so the
// rounder still sees it; bits shifted out on the left are always zero
// because the left walk stops at the hidden bit

`include "fpu_norm_defs.svh"

module norm_shifter
	import fpu_norm_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   load,
	input  fract_t fract_in,
	input  logic   shift_left,
	input  logic   shift_right,
	output fract_t fract_cur,
	output logic   sticky_extra,
	output logic   hidden_set,
	output logic   carry_set,
	output logic   fract_zero
);

	fract_t fract_q;
	logic sticky_q;

	// --------------------
	// fraction register

	always_ff @(posedge clk) begin
		if (load)
			fract_q <= fract_in;
		else if (shift_right)
			fract_q <= {1'b0, fract_q[`FN_FRACT_W-1:1]};
		else if (shift_left)
			fract_q <= {fract_q[`FN_FRACT_W-2:0], 1'b0};
	end

	// --------------------
	// sticky capture

	// cleared for every new operand, collects the lsb on a right shift
	always_ff @(posedge clk) begin
		if (reset)
			sticky_q <= 1'b0;
		else if (load)
			sticky_q <= 1'b0;
		else if (shift_right)
			sticky_q <= sticky_q | fract_q[0];
	end

	// --------------------
	// status

	assign fract_cur = fract_q;
	assign sticky_extra = sticky_q;
	// top bit is the adder carry out
	assign carry_set = fract_q[`FN_FRACT_W-1];
	assign hidden_set = fract_q[`FN_HIDDEN];
	// zero result, nothing to normalise
	assign fract_zero = ~|fract_q;

	// load and shift share the register, only one may act per cycle
	assert property (@(posedge clk) disable iff (reset)
		load |-> !(shift_left || shift_right))
		else $error("shift requested in the load cycle");

endmodule

// File: hdl/post_norm.sv
// post normalisation and rounding for single precision add/sub
// results, done serially over several cycles
// handshake is four phase req/ack; hold fract_in, exp_in, sign and
// rmode stable from req until ack
// exp_in must be at least 1 unless fract_in is zero
// out carries exponent and mantissa only, the sign is not packed

`include "fpu_norm_defs.svh"

module post_norm
	import fpu_norm_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    req,
	input  fract_t  fract_in,
	input  exp_t    exp_in,
	input  logic    sign,
	input  rmode_e  rmode,
	output logic    ack,
	output result_t out,
	output logic    overflow,
	output logic    underflow,
	output logic    ine
);

	// sequencer strobes
	logic load;
	logic shift_left;
	logic shift_right;
	logic do_round;
	// datapath status
	logic hidden_set;
	logic carry_set;
	logic fract_zero;
	logic at_floor;
	logic sticky_extra;
	fract_t fract_cur;
	exp_t exp_cur;

	// --------------------
	// control

	norm_ctrl u_ctrl (
		.clk         (clk),
		.reset       (reset),
		.req         (req),
		.hidden_set  (hidden_set),
		.carry_set   (carry_set),
		.fract_zero  (fract_zero),
		.at_floor    (at_floor),
		.load        (load),
		.shift_left  (shift_left),
		.shift_right (shift_right),
		.do_round    (do_round),
		.ack         (ack)
	);

	// --------------------
	// datapath

	norm_exp_counter u_exp (
		.clk         (clk),
		.reset       (reset),
		.load        (load),
		.exp_in      (exp_in),
		.shift_left  (shift_left),
		.shift_right (shift_right),
		.exp_cur     (exp_cur),
		.at_floor    (at_floor)
	);

	norm_shifter u_shift (
		.clk          (clk),
		.reset        (reset),
		.load         (load),
		.fract_in     (fract_in),
		.shift_left   (shift_left),
		.shift_right  (shift_right),
		.fract_cur    (fract_cur),
		.sticky_extra (sticky_extra),
		.hidden_set   (hidden_set),
		.carry_set    (carry_set),
		.fract_zero   (fract_zero)
	);

	norm_round u_round (
		.clk          (clk),
		.reset        (reset),
		.do_round     (do_round),
		.fract_cur    (fract_cur),
		.sticky_extra (sticky_extra),
		.exp_cur      (exp_cur),
		.sign         (sign),
		.rmode        (rmode),
		.out          (out),
		.overflow     (overflow),
		.underflow    (underflow),
		.ine          (ine)
	);

endmodule

// File: src.f
+incdir+hdl
hdl/fpu_norm_pkg.sv
hdl/norm_ctrl.sv
hdl/norm_exp_counter.sv
hdl/norm_shifter.sv
hdl/norm_round.sv
hdl/post_norm.sv
test/tb_post_norm.sv

// File: test/tb_post_norm.sv
// testbench for the serial post normalisation unit
// random operands from a fixed seed, checked against a behavioural model
// the model follows the IEEE rounding rules, not the RTL structure
// the sign is not part of the packed result, only rounding uses it
// one item in flight, the four phase handshake is followed exactly

`include "fpu_norm_defs.svh"

module tb_post_norm
	import fpu_norm_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_TXN = 2000;
	// worst case is 46 left shifts plus handshake overhead
	localparam int CYC_PER_TXN = 60;
	localparam int RESET_CYCLES = 16;
	localparam int TIMEOUT_CYCLES = NUM_TXN * CYC_PER_TXN + RESET_CYCLES;

	logic    clk;
	logic    reset;
	logic    req;
	fract_t  fract_in;
	exp_t    exp_in;
	logic    sign;
	rmode_e  rmode;
	logic    ack;
	result_t out;
	logic    overflow;
	logic    underflow;
	logic    ine;

	int err_result;
	int err_flag;
	int err_hs;
	int cycles;

	post_norm dut (
		.clk       (clk),
		.reset     (reset),
		.req       (req),
		.fract_in  (fract_in),
		.exp_in    (exp_in),
		.sign      (sign),
		.rmode     (rmode),
		.ack       (ack),
		.out       (out),
		.overflow  (overflow),
		.underflow (underflow),
		.ine       (ine)
	);

	// --------------------
	// compare tasks

	task automatic check_result(input string name, input result_t expected, input result_t actual);
		if (actual !== expected) begin
			$display("ERR %s: expected %h, actual %h", name, expected, actual);
			err_result++;
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("ERR %s: expected %b, actual %b", name, expected, actual);
			err_flag++;
		end
	endtask

	// expected is the ack level the protocol requires at this point
	task automatic check_handshake(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			if (expected)
				$display("%s: ack did not rise or dropped too early", name);
			else
				$display("%s: ack is stuck high when it should be low", name);
			err_hs++;
		end
	endtask

	// --------------------
	// reference model

	task automatic compute_expected(input fract_t f, input exp_t e, input logic s,
		input rmode_e m, output result_t r, output logic ovf, output logic unf,
		output logic inx);
		fract_t fr;
		int ex;
		logic lost;
		logic g;
		logic st;
		logic up;
		logic away;
		logic [24:0] sig;
		ex = e;
		lost = 1'b0;
		fr = f;
		// normalise, carry means one step right, else walk left to the hidden bit
		if (fr[`FN_FRACT_W-1]) begin
			lost = fr[0];
			fr = fr >> 1;
			ex = ex + 1;
		end else begin
			while (fr != '0 && !fr[`FN_HIDDEN] && ex > 1) begin
				fr = fr << 1;
				ex = ex - 1;
			end
		end
		g = fr[22];
		st = (|fr[21:0]) | lost;
		case (m)
			rm_nearest: up = g & (st | fr[23]);
			rm_up: up = ~s & (g | st);
			rm_down: up = s & (g | st);
			default: up = 1'b0;
		endcase
		sig = {1'b0, fr[46:23]} + 25'(up);
		// mantissa overflowed into a new leading one
		if (sig[24]) begin
			sig = sig >> 1;
			ex = ex + 1;
		end
		ovf = (ex >= 255);
		if (ovf) begin
			away = (m == rm_nearest) || (m == rm_up && !s) || (m == rm_down && s);
			r = away ? {8'hff, 23'h000000} : {8'hfe, 23'h7fffff};
		end else begin
			r = {(sig[23] ? 8'(ex) : 8'h00), sig[22:0]};
		end
		inx = g | st | ovf;
		unf = (r[30:23] == 8'h00) && inx;
	endtask

	// --------------------
	// stimulus

	function automatic fract_t rand_fract();
		logic [63:0] r;
		r = {$urandom(), $urandom()};
		return r[`FN_FRACT_W-1:0];
	endfunction

	task automatic pick_operands(output fract_t f, output exp_t e, output string kind);
		int k;
		fract_t r;
		r = rand_fract();
		k = $urandom_range(46, 1);
		f = r;
		e = exp_t'($urandom_range(254, 1));
		case ($urandom_range(6, 0))
			0: begin
				kind = "carry";
				f[47] = 1'b1;
			end
			1: begin
				kind = "left shift";
				f = r >> (k + 1);
				f[`FN_HIDDEN-k] = 1'b1;
			end
			2: begin
				// small exponent so the walk often hits the floor
				kind = "floor";
				f = r >> (k + 1);
				f[`FN_HIDDEN-k] = 1'b1;
				e = exp_t'($urandom_range(24, 1));
			end
			3: begin
				kind = "zero";
				f = '0;
			end
			4: begin
				kind = "near overflow";
				e = exp_t'($urandom_range(254, 253));
				f[47] = 1'b1;
				if ($urandom_range(1, 0)) begin
					f[47] = 1'b0;
					f[46] = 1'b1;
					f[45:23] = '1;
				end
			end
			5: begin
				kind = "round carry";
				f[47] = 1'b0;
				f[46] = 1'b1;
				f[45:23] = '1;
			end
			default: begin
				kind = "normal";
				f[47] = 1'b0;
				f[46] = 1'b1;
			end
		endcase
	endtask

	// returns with seen set once ack reads level, or after CYC_PER_TXN edges
	task automatic wait_ack(input logic level, output logic seen);
		int n;
		seen = 1'b0;
		n = 0;
		while (!seen && n < CYC_PER_TXN) begin
			@(posedge clk);
			n++;
			if (ack === level)
				seen = 1'b1;
		end
	endtask

	task automatic run_txn(input int idx);
		fract_t f;
		exp_t e;
		logic s;
		rmode_e m;
		string kind;
		string name;
		result_t exp_r;
		logic exp_o;
		logic exp_u;
		logic exp_i;
		logic seen;
		int hold;
		pick_operands(f, e, kind);
		s = 1'($urandom_range(1, 0));
		m = rmode_e'($urandom_range(3, 0));
		name = $sformatf("txn %0d %s", idx, kind);
		compute_expected(f, e, s, m, exp_r, exp_o, exp_u, exp_i);
		// one idle cycle with req low, ack must not rise before the request
		@(posedge clk);
		check_handshake({name, " idle"}, 1'b0, ack);
		req <= 1'b1;
		fract_in <= f;
		exp_in <= e;
		sign <= s;
		rmode <= m;
		wait_ack(1'b1, seen);
		check_handshake({name, " ack rise"}, 1'b1, seen);
		if (seen) begin
			check_result({name, " out"}, exp_r, out);
			check_flag({name, " overflow"}, exp_o, overflow);
			check_flag({name, " underflow"}, exp_u, underflow);
			check_flag({name, " ine"}, exp_i, ine);
		end
		// back pressure, the result has to stay put
		hold = $urandom_range(2, 0);
		repeat (hold) begin
			@(posedge clk);
			check_result({name, " held out"}, exp_r, out);
			check_handshake({name, " held ack"}, 1'b1, ack);
		end
		req <= 1'b0;
		wait_ack(1'b0, seen);
		check_handshake({name, " ack fall"}, 1'b0, ~seen);
	endtask

	// --------------------
	// clock, timeout and main sequence

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		void'($urandom(32'hed76e76e));
		err_result = 0;
		err_flag = 0;
		err_hs = 0;
		reset = 1'b1;
		req = 1'b0;
		fract_in = '0;
		exp_in = '0;
		sign = 1'b0;
		rmode = rm_nearest;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		// state straight out of reset
		check_handshake("reset ack", 1'b0, ack);
		check_flag("reset overflow", 1'b0, overflow);
		check_flag("reset underflow", 1'b0, underflow);
		check_flag("reset ine", 1'b0, ine);
		for (int i = 0; i < NUM_TXN; i++)
			run_txn(i);
		$display("errors: result %0d, flag %0d, handshake %0d", err_result, err_flag, err_hs);
		if (err_result + err_flag + err_hs == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule
